//--- Bender.yml
package:
  name: nts_engine

sources:
  - verilog/nts_api_pkg.sv
  - verilog/nts_debug_pkg.sv
  - verilog/nts_api_bus_if.sv
  - verilog/nts_api_decoder.sv
  - verilog/nts_engine_info.sv
  - verilog/nts_stat_counter.sv
  - verilog/nts_debug_regs.sv
  - verilog/nts_engine_top.sv
  - target: simulation
    files:
      - bench/tb_nts_engine.sv

//--- bench/nts_engine_patterns.txt
# op a [b], all fields hex. R/N addr expect: read with cs high/low. W addr data: write.
# E event mask, I idle cycles, T tick gap cycles, H/L counter index, B burst cycles.
R 000 4e54535f
R 001 454e474e
R 002 302e3031
R 008 00000001
R 003 00000000
R 308 44425547
H 0
L 0
E 01
E 3f
E 15
H 0
L 0
H 4
E 10
E 10
L 4
H 4
L 4
T 5
T 1f
W 000 deadbeef
W 300 12345678
R 000 4e54535f
H 0
L 0
R 100 00000000
R 200 00000000
R 400 00000000
R 30a 00000000
N 000 00000000
N 308 00000000
B 40

//--- bench/tb_nts_engine.sv
// Self-checking testbench for the NTS engine register side.
// Runs the operations listed in bench/nts_engine_patterns.txt against
// a model of the six event counters and their low word snapshots.

`timescale 1ns/1ns
`default_nettype none

module tb_nts_engine;

  logic                        clk;
  logic                        areset;
  logic                        api_cs;
  logic                        api_we;
  nts_api_pkg::api_addr_t      api_address;
  nts_api_pkg::api_data_t      api_write_data;
  nts_api_pkg::api_data_t      api_read_data;
  nts_debug_pkg::stat_events_t stat_events;

  nts_debug_pkg::stat_count_t model_count [nts_debug_pkg::STAT_COUNT];
  nts_api_pkg::api_data_t     model_snap  [nts_debug_pkg::STAT_COUNT];

  byte         op_q    [$];  // One entry per pattern line
  logic [31:0] arg_a_q [$];
  logic [31:0] arg_b_q [$];
  int          limit_cycles = 0;

  localparam nts_api_pkg::api_addr_t TICK_ADDR =
    {nts_api_pkg::CORE_SEL_DEBUG, nts_debug_pkg::ADDR_DEBUG_SYSTICK32};

  nts_engine_top u_nts_engine_top (
    .i_clk            (clk),
    .i_areset         (areset),
    .i_api_cs         (api_cs),
    .i_api_we         (api_we),
    .i_api_address    (api_address),
    .i_api_write_data (api_write_data),
    .o_api_read_data  (api_read_data),
    .i_stat_events    (stat_events)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //----------------------------------------
  // Error handling and compares
  //----------------------------------------

  task automatic abort_run(input string reason);
    $display("Verification failed");
    $fatal(1, "Run stopped: %s", reason);
  endtask

  task automatic check_data(input nts_api_pkg::api_addr_t addr,
                            input nts_api_pkg::api_data_t expected,
                            input nts_api_pkg::api_data_t actual);
    if (actual !== expected)
    begin
      $display("ERR %0t: read of %h expected %h got %h", $time, addr, expected, actual);
      abort_run("register read mismatch");
    end
  endtask

  task automatic check_tick(input nts_api_pkg::api_data_t expected,
                            input nts_api_pkg::api_data_t actual);
    if (actual !== expected)
    begin
      $display("ERR %0t: tick delta at %h expected %h got %h", $time, TICK_ADDR, expected,
               actual);
      abort_run("system tick mismatch");
    end
  endtask

  //----------------------------------------
  // Bus and event drivers
  //----------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic bus_read(input logic cs, input nts_api_pkg::api_addr_t addr,
                          output nts_api_pkg::api_data_t data);
    next_cycle();
    api_cs      = cs;
    api_we      = 1'b0;
    api_address = addr;
    stat_events = '0;
    @(negedge clk);  // Read data settled by mid cycle
    data = api_read_data;
  endtask

  task automatic read_expect(input logic cs, input nts_api_pkg::api_addr_t addr,
                             input nts_api_pkg::api_data_t expected);
    nts_api_pkg::api_data_t data;
    bus_read(cs, addr, data);
    check_data(addr, expected, data);
  endtask

  task automatic bus_write(input nts_api_pkg::api_addr_t addr,
                           input nts_api_pkg::api_data_t data);
    next_cycle();
    api_cs         = 1'b1;
    api_we         = 1'b1;
    api_address    = addr;
    api_write_data = data;
    stat_events    = '0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      next_cycle();
      api_cs      = 1'b0;
      api_we      = 1'b0;
      stat_events = '0;
    end
  endtask

  task automatic pulse_events(input nts_debug_pkg::stat_events_t mask);
    next_cycle();
    api_cs      = 1'b0;
    api_we      = 1'b0;
    stat_events = mask;
    for (int i = 0; i < nts_debug_pkg::STAT_COUNT; i++)
      if (mask[i])
        model_count[i] += 1;  // Lands at the coming edge
  endtask

  //----------------------------------------
  // Counter and tick operations
  //----------------------------------------

  function automatic nts_api_pkg::api_addr_t high_addr(input int idx);
    nts_api_pkg::api_offset_t offset;
    case (idx)
      nts_debug_pkg::STAT_NTS_PROCESSED:  offset = nts_debug_pkg::ADDR_DEBUG_NTS_PROCESSED;
      nts_debug_pkg::STAT_NTS_BAD_COOKIE: offset = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_COOKIE;
      nts_debug_pkg::STAT_NTS_BAD_AUTH:   offset = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_AUTH;
      nts_debug_pkg::STAT_NTS_BAD_KEYID:  offset = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_KEYID;
      nts_debug_pkg::STAT_ERROR_CRYPTO:   offset = nts_debug_pkg::ADDR_DEBUG_ERROR_CRYPTO;
      default:                            offset = nts_debug_pkg::ADDR_DEBUG_ERROR_TXBUF;
    endcase
    return {nts_api_pkg::CORE_SEL_DEBUG, offset};
  endfunction

  task automatic read_high(input int idx);
    read_expect(1'b1, high_addr(idx), model_count[idx][63:32]);
    model_snap[idx] = model_count[idx][31:0];  // Loaded by this read
  endtask

  task automatic read_low(input int idx);
    read_expect(1'b1, high_addr(idx) + 12'd1, model_snap[idx]);
  endtask

  // Second read lands exactly gap cycles after the first
  task automatic tick_gap(input int gap);
    nts_api_pkg::api_data_t first;
    nts_api_pkg::api_data_t second;
    bus_read(1'b1, TICK_ADDR, first);
    idle(gap - 1);
    bus_read(1'b1, TICK_ADDR, second);
    check_tick(gap, second - first);
  endtask

  task automatic random_burst(input int cycles);
    repeat (cycles)
      pulse_events(nts_debug_pkg::stat_events_t'($urandom));
    for (int i = 0; i < nts_debug_pkg::STAT_COUNT; i++)
    begin
      read_high(i);
      read_low(i);
    end
  endtask

  //----------------------------------------
  // Pattern load and run
  //----------------------------------------

  initial
  begin
    int           fd;
    int           code;
    int           burst_total;
    byte          op;
    logic [63:0]  op_tok;
    logic [1023:0] line_buf;
    logic [31:0]  arg_a;
    logic [31:0]  arg_b;

    void'($urandom(32'h812d));
    areset         = 1'b1;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    stat_events    = '0;
    burst_total    = 0;
    foreach (model_count[i])
    begin
      model_count[i] = '0;
      model_snap[i]  = '0;
    end

    fd = $fopen("bench/nts_engine_patterns.txt", "r");
    if (fd == 0)
      abort_run("cannot open bench/nts_engine_patterns.txt");
    while ($fscanf(fd, "%s", op_tok) == 1)
    begin
      op = op_tok[7:0];
      if (op == "#")
        code = $fgets(line_buf, fd);  // Rest of a comment line
      else
      begin
        arg_b = '0;
        if (op == "R" || op == "N" || op == "W")
          code = $fscanf(fd, "%h %h", arg_a, arg_b);
        else
          code = $fscanf(fd, "%h", arg_a);
        if (code < 1)
          abort_run("malformed line in pattern file");
        if (op == "B")
          burst_total += arg_a;
        op_q.push_back(op);
        arg_a_q.push_back(arg_a);
        arg_b_q.push_back(arg_b);
      end
    end
    $fclose(fd);
    limit_cycles = op_q.size() * 64 + burst_total;

    repeat (4) @(posedge clk);
    #1 areset = 1'b0;

    foreach (op_q[i])
    begin
      case (op_q[i])
        "R": read_expect(1'b1, nts_api_pkg::api_addr_t'(arg_a_q[i]), arg_b_q[i]);
        // cs held low
        "N": read_expect(1'b0, nts_api_pkg::api_addr_t'(arg_a_q[i]), arg_b_q[i]);
        "W": bus_write(nts_api_pkg::api_addr_t'(arg_a_q[i]), arg_b_q[i]);
        "E": pulse_events(nts_debug_pkg::stat_events_t'(arg_a_q[i]));
        "I": idle(arg_a_q[i]);
        "T": tick_gap(arg_a_q[i]);
        "H": read_high(arg_a_q[i]);
        "L": read_low(arg_a_q[i]);
        "B": random_burst(arg_a_q[i]);
        default: abort_run("unknown operation in pattern file");
      endcase
    end

    idle(2);
    $display("Verification passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the pattern run did not finish within %0d cycles", limit_cycles);
    abort_run("watchdog expired");
  end

endmodule

`default_nettype wire

//--- tb.f
verilog/nts_api_pkg.sv
verilog/nts_debug_pkg.sv
verilog/nts_api_bus_if.sv
verilog/nts_api_decoder.sv
verilog/nts_engine_info.sv
verilog/nts_stat_counter.sv
verilog/nts_debug_regs.sv
verilog/nts_engine_top.sv
bench/tb_nts_engine.sv

//--- verilog/nts_api_bus_if.sv
// One core's slice of the internal register bus.
// The decoder drives select and request, the core answers with read data.

`timescale 1ns/1ns
`default_nettype none

interface nts_api_bus_if ();

  logic                     cs;          // Raised only for this core
  logic                     we;
  nts_api_pkg::api_offset_t offset;
  nts_api_pkg::api_data_t   write_data;
  nts_api_pkg::api_data_t   read_data;   // Same cycle as cs

  modport decoder (output cs, we, offset, write_data, input read_data);
  modport core (input cs, we, offset, write_data, output read_data);

endinterface

`default_nettype wire

//--- verilog/nts_api_decoder.sv
// Register bus decoder.
// Splits the 12-bit address into core select and offset, raises the
// matching core's cs and returns that core's read data in the same cycle.

`timescale 1ns/1ns
`default_nettype none

module nts_api_decoder (
  input  wire                        i_api_cs,
  input  wire                        i_api_we,
  input  wire nts_api_pkg::api_addr_t i_api_address,
  input  wire nts_api_pkg::api_data_t i_api_write_data,
  output nts_api_pkg::api_data_t      o_api_read_data,

  nts_api_bus_if.decoder             engine_bus,
  nts_api_bus_if.decoder             debug_bus
);

  nts_api_pkg::api_core_sel_t core_sel;
  nts_api_pkg::api_offset_t   offset;

  assign {core_sel, offset} = i_api_address;

  //----------------------------------------
  // Request fan-out
  //----------------------------------------

  assign engine_bus.cs = i_api_cs && (core_sel == nts_api_pkg::CORE_SEL_ENGINE);
  assign debug_bus.cs  = i_api_cs && (core_sel == nts_api_pkg::CORE_SEL_DEBUG);

  // Shared by both cores
  assign engine_bus.we         = i_api_we;
  assign engine_bus.offset     = offset;
  assign engine_bus.write_data = i_api_write_data;
  assign debug_bus.we          = i_api_we;
  assign debug_bus.offset      = offset;
  assign debug_bus.write_data  = i_api_write_data;

  //----------------------------------------
  // Read data merge
  //----------------------------------------

  always_comb
  begin
    o_api_read_data = '0;
    if (i_api_cs)
    begin
      case (core_sel)
        nts_api_pkg::CORE_SEL_ENGINE: o_api_read_data = engine_bus.read_data;
        nts_api_pkg::CORE_SEL_DEBUG:  o_api_read_data = debug_bus.read_data;
        default: ;  // Dropped cores and unused codes read zero
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/nts_api_pkg.sv
// Register bus types and identity core constants.
// Shared by the address decoder, the identity core and the top level.
// Refer to members by scoped name.

`default_nettype none

package nts_api_pkg;

  //----------------------------------------
  // Bus widths
  //----------------------------------------

  typedef logic [11:0] api_addr_t;      // External register address
  typedef logic [7:0]  api_offset_t;    // Address within one core
  typedef logic [3:0]  api_core_sel_t;  // Upper address bits
  typedef logic [31:0] api_data_t;      // One register word

  //----------------------------------------
  // Core select codes
  //----------------------------------------

  // Codes 1, 2 and 4 belonged to the clock, cookie and key memory cores
  localparam api_core_sel_t CORE_SEL_ENGINE = 4'h0;
  localparam api_core_sel_t CORE_SEL_DEBUG  = 4'h3;

  //----------------------------------------
  // Identity core
  //----------------------------------------

  localparam api_offset_t ADDR_NAME0   = 8'h00;
  localparam api_offset_t ADDR_NAME1   = 8'h01;
  localparam api_offset_t ADDR_VERSION = 8'h02;
  localparam api_offset_t ADDR_CTRL    = 8'h08;

  localparam api_data_t CORE_NAME0   = 32'h4e_54_53_5f;  // "NTS_"
  localparam api_data_t CORE_NAME1   = 32'h45_4e_47_4e;  // "ENGN"
  localparam api_data_t CORE_VERSION = 32'h30_2e_30_31;  // "0.01"
  localparam api_data_t CTRL_VALUE   = 32'h0000_0001;

endpackage

`default_nettype wire

//--- verilog/nts_debug_pkg.sv
// Debug core address map, counter indices and widths.
// Event bit i of the pulse vector feeds counter index i.

`default_nettype none

package nts_debug_pkg;

  localparam int STAT_COUNT = 6;

  typedef logic [STAT_COUNT-1:0] stat_events_t;  // One pulse bit per counter
  typedef logic [63:0]           stat_count_t;

  // Counter indices
  localparam int STAT_NTS_PROCESSED  = 0;
  localparam int STAT_NTS_BAD_COOKIE = 1;
  localparam int STAT_NTS_BAD_AUTH   = 2;
  localparam int STAT_NTS_BAD_KEYID  = 3;
  localparam int STAT_ERROR_CRYPTO   = 4;
  localparam int STAT_ERROR_TXBUF    = 5;

  // High word offsets, low word follows at +1
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_NTS_PROCESSED  = 8'h00;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_NTS_BAD_COOKIE = 8'h02;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_NTS_BAD_AUTH   = 8'h04;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_NTS_BAD_KEYID  = 8'h06;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_ERROR_CRYPTO   = 8'h20;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_ERROR_TXBUF    = 8'h22;

  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_NAME      = 8'h08;
  localparam nts_api_pkg::api_offset_t ADDR_DEBUG_SYSTICK32 = 8'h09;

  localparam nts_api_pkg::api_data_t DEBUG_NAME    = 32'h44_42_55_47;  // "DBUG"
  localparam nts_api_pkg::api_data_t SYSTICK_RESET = 32'h0000_0001;

endpackage

`default_nettype wire

//--- verilog/nts_debug_regs.sv
// Debug core with six event counters and a free-running system tick.
// Reading a counter's high word snapshots its low word, which is read
// at the next offset. Writes are ignored.

`timescale 1ns/1ns
`default_nettype none

module nts_debug_regs (
  input  wire                          i_clk,
  input  wire                          i_areset,
  input  wire nts_debug_pkg::stat_events_t i_stat_events,
  nts_api_bus_if.core                  bus
);

  nts_debug_pkg::stat_count_t           stat_count    [nts_debug_pkg::STAT_COUNT];
  nts_api_pkg::api_data_t               stat_snapshot [nts_debug_pkg::STAT_COUNT];
  nts_api_pkg::api_offset_t             stat_addr     [nts_debug_pkg::STAT_COUNT];
  logic [nts_debug_pkg::STAT_COUNT-1:0] snap_strobe;
  nts_api_pkg::api_data_t               systick32;
  nts_api_pkg::api_data_t               read_data;

  //----------------------------------------
  // Counters
  //----------------------------------------

  // High word offset per counter index
  assign stat_addr[nts_debug_pkg::STAT_NTS_PROCESSED]  = nts_debug_pkg::ADDR_DEBUG_NTS_PROCESSED;
  assign stat_addr[nts_debug_pkg::STAT_NTS_BAD_COOKIE] = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_COOKIE;
  assign stat_addr[nts_debug_pkg::STAT_NTS_BAD_AUTH]   = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_AUTH;
  assign stat_addr[nts_debug_pkg::STAT_NTS_BAD_KEYID]  = nts_debug_pkg::ADDR_DEBUG_NTS_BAD_KEYID;
  assign stat_addr[nts_debug_pkg::STAT_ERROR_CRYPTO]   = nts_debug_pkg::ADDR_DEBUG_ERROR_CRYPTO;
  assign stat_addr[nts_debug_pkg::STAT_ERROR_TXBUF]    = nts_debug_pkg::ADDR_DEBUG_ERROR_TXBUF;

  for (genvar i = 0; i < nts_debug_pkg::STAT_COUNT; i++)
  begin : g_stat
    nts_stat_counter u_nts_stat_counter (
      .i_clk      (i_clk),
      .i_areset   (i_areset),
      .i_event    (i_stat_events[i]),
      .i_snapshot (snap_strobe[i]),
      .o_count    (stat_count[i]),
      .o_snapshot (stat_snapshot[i])
    );
  end

  // Free-running tick
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick32 <= nts_debug_pkg::SYSTICK_RESET;
    else
      systick32 <= systick32 + 1'b1;
  end

  //----------------------------------------
  // Read decode
  //----------------------------------------

  always_comb
  begin
    read_data   = '0;
    snap_strobe = '0;
    if (bus.cs && !bus.we)
    begin
      for (int i = 0; i < nts_debug_pkg::STAT_COUNT; i++)
      begin
        if (bus.offset == stat_addr[i])
        begin
          read_data      = stat_count[i][63:32];
          snap_strobe[i] = 1'b1;
        end
        else if (bus.offset == nts_api_pkg::api_offset_t'(stat_addr[i] + 8'd1))
        begin
          read_data = stat_snapshot[i];  // Low word as of last high read
        end
      end

      case (bus.offset)
        nts_debug_pkg::ADDR_DEBUG_NAME:      read_data = nts_debug_pkg::DEBUG_NAME;
        nts_debug_pkg::ADDR_DEBUG_SYSTICK32: read_data = systick32;
        default: ;
      endcase
    end
  end

  assign bus.read_data = read_data;

endmodule

`default_nettype wire

//--- verilog/nts_engine_info.sv
// Read-only identity core: name, version and control words.
// Writes are ignored.

`timescale 1ns/1ns
`default_nettype none

module nts_engine_info (
  nts_api_bus_if.core bus
);

  always_comb
  begin
    bus.read_data = '0;
    if (bus.cs && !bus.we)
    begin
      case (bus.offset)
        nts_api_pkg::ADDR_NAME0:   bus.read_data = nts_api_pkg::CORE_NAME0;
        nts_api_pkg::ADDR_NAME1:   bus.read_data = nts_api_pkg::CORE_NAME1;
        nts_api_pkg::ADDR_VERSION: bus.read_data = nts_api_pkg::CORE_VERSION;
        nts_api_pkg::ADDR_CTRL:    bus.read_data = nts_api_pkg::CTRL_VALUE;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/nts_engine_top.sv
// Register side of the NTS engine.
// Host register bus on plain ports, counter events as a pulse vector.
// Read data is combinational and valid in the access cycle.

`timescale 1ns/1ns
`default_nettype none

module nts_engine_top (
  input  wire                              i_clk,
  input  wire                              i_areset,

  input  wire                              i_api_cs,
  input  wire                              i_api_we,
  input  wire nts_api_pkg::api_addr_t      i_api_address,
  input  wire nts_api_pkg::api_data_t      i_api_write_data,
  output wire nts_api_pkg::api_data_t      o_api_read_data,

  input  wire nts_debug_pkg::stat_events_t i_stat_events
);

  //----------------------------------------
  // Internal bus slices
  //----------------------------------------

  nts_api_bus_if engine_bus ();
  nts_api_bus_if debug_bus ();

  nts_api_decoder u_nts_api_decoder (
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_api_read_data  (o_api_read_data),
    .engine_bus       (engine_bus),
    .debug_bus        (debug_bus)
  );

  //----------------------------------------
  // Cores
  //----------------------------------------

  nts_engine_info u_nts_engine_info (
    .bus (engine_bus)
  );

  nts_debug_regs u_nts_debug_regs (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_stat_events (i_stat_events),  // Stand-in for parser, crypto and txbuf
    .bus           (debug_bus)
  );

endmodule

`default_nettype wire

//--- verilog/nts_stat_counter.sv
// One 64-bit event counter with a low word snapshot.
// The snapshot is loaded when the high word is read, so a following
// low word read belongs to the same count.

`timescale 1ns/1ns
`default_nettype none

module nts_stat_counter (
  input  wire                          i_clk,
  input  wire                          i_areset,
  input  wire                          i_event,     // One count per cycle high
  input  wire                          i_snapshot,  // High word read strobe
  output nts_debug_pkg::stat_count_t   o_count,
  output nts_api_pkg::api_data_t       o_snapshot
);

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_count    <= '0;
      o_snapshot <= '0;
    end
    else
    begin
      if (i_event)
      begin
        o_count <= o_count + 1'b1;
      end

      // Value before this edge's increment, matching the high word just read
      if (i_snapshot)
      begin
        o_snapshot <= o_count[31:0];
      end
    end
  end

endmodule

`default_nettype wire
